/* dbg_golden.txt */
# test <name>, then "in" with the slave packets and "out" with the expected master bytes
# A | closes a packet (tlast). rd <addr> and wr <addr> <data> are expected accesses. Hex.
test not_version     in 02 02 aa 55 00 10 |  out 02 02 aa 55 00 10 |
test two_packets     in 07 | 02 01 ff |  out 07 | 02 01 ff |
test version_only    in 01 |  out 01 |
test identify        in 01 00 |  out 01 00 | 01 01 aa 55 02 03 |
test plain_identify  in 05 06 | 01 00 |
                     out 05 06 | 01 00 | 01 01 aa 55 02 03 |
test read_init       in 01 02 aa 55 00 10 |
                     out 01 02 aa 55 00 10 | 01 03 aa 55 00 10 00 00 30 |  rd 0010
test write           in 01 04 aa 55 00 10 12 34 56 |
                     out 01 04 aa 55 00 10 12 34 56 |  wr 0010 123456
test read_back       in 01 02 aa 55 01 10 |
                     out 01 02 aa 55 01 10 | 01 03 aa 55 01 10 12 34 56 |  rd 0110
test read_top        in 01 02 aa 55 12 ff |
                     out 01 02 aa 55 12 ff | 01 03 aa 55 12 ff 00 00 fd |  rd 12ff
test plain_read      in 09 | 01 02 aa 55 00 03 |
                     out 09 | 01 02 aa 55 00 03 | 01 03 aa 55 00 03 00 00 09 |  rd 0003
test wrong_id        in 01 02 aa 56 00 20 |  out 01 02 aa 56 00 20 |
test wrong_type      in 01 04 ab 55 00 20 11 22 33 |  out 01 04 ab 55 00 20 11 22 33 |
test unknown_cmd     in 01 03 aa 55 00 20 |  out 01 03 aa 55 00 20 |
test short_cmd       in 01 02 |  out 01 02 |
test short_read      in 01 02 aa 55 00 |  out 01 02 aa 55 00 |
test short_write     in 01 04 aa 55 00 20 11 22 |  out 01 04 aa 55 00 20 11 22 |
test read_untouched  in 01 02 aa 55 00 20 |
                     out 01 02 aa 55 00 20 | 01 03 aa 55 00 20 00 00 60 |  rd 0020
test write_high      in 01 04 aa 55 00 80 ab cd ef |
                     out 01 04 aa 55 00 80 ab cd ef |  wr 0080 abcdef
test read_high       in 01 02 aa 55 00 80 |
                     out 01 02 aa 55 00 80 | 01 03 aa 55 00 80 ab cd ef |  rd 0080

/* tb.f */
dbg_pkg.sv
dbg_ifs.sv
dbg_stream_forwarder.sv
dbg_cmd_parser.sv
dbg_resp_builder.sv
axis_debug_decoder.sv
tb_axis_debug_decoder.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_axis_debug_decoder -f tb.f \
    -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

/* tb_axis_debug_decoder.sv */
`default_nettype none

module tb_axis_debug_decoder;

    localparam int ADDR_BYTES    = 2;
    localparam int DATA_BYTES    = 3;
    localparam int MAX_TESTS     = 32;
    localparam int MAX_BYTES     = 48;
    localparam int MAX_ACCESSES  = 4;
    localparam int SETTLE_CYCLES = 20;

    logic                      clk;
    logic                      rst_n;
    logic                      s_tvalid;
    logic                      s_tready;
    logic [7:0]                s_tdata;
    logic                      s_tlast;
    logic                      m_tvalid;
    logic                      m_tready;
    logic [7:0]                m_tdata;
    logic                      m_tlast;
    logic [ADDR_BYTES*8-1:0]   rw_address;
    logic [DATA_BYTES*8-1:0]   write_data;
    logic [DATA_BYTES*8-1:0]   read_data;
    logic                      read_request;
    logic                      write_request;
    logic                      output_valid;

    // Golden tests with tlast in bit 8 of each stream entry
    string       test_name [MAX_TESTS];
    logic [8:0]  in_bytes  [MAX_TESTS][MAX_BYTES];
    int          in_len    [MAX_TESTS];
    logic [8:0]  out_bytes [MAX_TESTS][MAX_BYTES];
    int          out_len   [MAX_TESTS];
    // Access entry is {is_write, address, write data}
    logic [40:0] acc_exp   [MAX_TESTS][MAX_ACCESSES];
    int          acc_len   [MAX_TESTS];
    int          num_tests    = 0;
    int          golden_bytes = 0;
    logic        load_error   = 1'b0;
    string       tokens[$];

    int          cur_test    = 0;
    int          out_base    = 0;
    int          acc_base    = 0;
    int          out_count   = 0;
    int          acc_count   = 0;
    int          errors      = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;
    logic [31:0] rng         = 32'hfcd2b69a;
    logic [23:0] reg_mem [256];

    axis_debug_decoder i_dut (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_s_tvalid      (s_tvalid),
        .o_s_tready      (s_tready),
        .i_s_tdata       (s_tdata),
        .i_s_tlast       (s_tlast),
        .o_m_tvalid      (m_tvalid),
        .i_m_tready      (m_tready),
        .o_m_tdata       (m_tdata),
        .o_m_tlast       (m_tlast),
        .o_rw_address    (rw_address),
        .o_write_data    (write_data),
        .i_read_data     (read_data),
        .o_read_request  (read_request),
        .o_write_request (write_request),
        .i_output_valid  (output_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s, %s: expected %0h, actual %0h", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic split_line(input string line);
        int  start;
        int  i;
        byte c;
        tokens.delete();
        start = -1;
        for (i = 0; i <= line.len(); i++) begin
            c = (i < line.len()) ? line[i] : 8'h20;
            if (c == " " || c == "\t" || c == "\n" || c == "\r") begin
                if (start >= 0) begin
                    tokens.push_back(line.substr(start, i - 1));
                end
                start = -1;
            end else if (start < 0) begin
                start = i;
            end
        end
    endtask

    // A test runs from its test token to the next one and may span lines
    task automatic load_golden();
        int    fd;
        int    t;
        int    k;
        string line;
        string tok;
        string arg;
        logic  in_section;
        t = -1;
        in_section = 1'b1;
        fd = $fopen("dbg_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open dbg_golden.txt, no tests were run");
            load_error = 1'b1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            split_line(line);
            k = 0;
            while (k < tokens.size()) begin
                tok = tokens[k];
                if (tok[0] == "#") begin
                    break;
                end else if (tok == "test") begin
                    t = num_tests;
                    num_tests++;
                    k++;
                    test_name[t] = tokens[k];
                    in_len[t]  = 0;
                    out_len[t] = 0;
                    acc_len[t] = 0;
                    in_section = 1'b1;
                end else if (tok == "in" || tok == "out") begin
                    in_section = (tok == "in");
                end else if (tok == "|") begin
                    if (in_section) begin
                        in_bytes[t][in_len[t] - 1][8] = 1'b1;
                    end else begin
                        out_bytes[t][out_len[t] - 1][8] = 1'b1;
                    end
                end else if (tok == "rd") begin
                    arg = tokens[k + 1];
                    acc_exp[t][acc_len[t]] = {1'b0, 16'(arg.atohex()), 24'h0};
                    acc_len[t]++;
                    k++;
                end else if (tok == "wr") begin
                    arg = tokens[k + 1];
                    acc_exp[t][acc_len[t]][40:24] = {1'b1, 16'(arg.atohex())};
                    arg = tokens[k + 2];
                    acc_exp[t][acc_len[t]][23:0] = 24'(arg.atohex());
                    acc_len[t]++;
                    k += 2;
                end else if (in_section) begin
                    in_bytes[t][in_len[t]] = {1'b0, 8'(tok.atohex())};
                    in_len[t]++;
                end else begin
                    out_bytes[t][out_len[t]] = {1'b0, 8'(tok.atohex())};
                    out_len[t]++;
                end
                k++;
            end
        end
        $fclose(fd);
        for (k = 0; k < num_tests; k++) begin
            golden_bytes += in_len[k] + out_len[k];
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after the handshake
    task automatic send_byte(input logic [8:0] entry);
        s_tvalid = 1'b1;
        s_tdata  = entry[7:0];
        s_tlast  = entry[8];
        // o_s_tready only changes on the rising edge
        while (!s_tready) begin
            @(negedge clk);
        end
        @(negedge clk);
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles in test %s", cycles, test_name[cur_test]);
            $display("Testbench failed");
            $finish;
        end
    end

    // Downstream sink and register model driven on the falling edge
    initial begin : downstream
        logic        busy;
        logic [2:0]  wait_cnt;
        logic [40:0] acc;
        logic [8:0]  got;
        int          idx;
        busy         = 1'b0;
        wait_cnt     = '0;
        m_tready     = 1'b0;
        output_valid = 1'b0;
        read_data    = '0;
        for (int a = 0; a < 256; a++) begin
            reg_mem[a] = {16'h0000, 8'(a * 3)};
        end
        forever begin
            @(negedge clk);
            rng = xorshift32(rng);
            if (output_valid) begin
                // The request was dropped on the edge that saw output_valid
                output_valid = 1'b0;
                busy         = 1'b0;
            end else begin
                if (!busy && (read_request || write_request)) begin
                    busy     = 1'b1;
                    wait_cnt = rng[10:8];
                    if (read_request && write_request) begin
                        $display("Test %s: read and write requested together",
                                 test_name[cur_test]);
                        errors++;
                    end
                    acc = {write_request, rw_address, write_request ? write_data : 24'h0};
                    idx = acc_count - acc_base;
                    if (idx < acc_len[cur_test]) begin
                        check_value(test_name[cur_test],
                                    $sformatf("register access %0d", idx),
                                    acc_exp[cur_test][idx], acc);
                    end else begin
                        $display("Test %s: unexpected register access %0h",
                                 test_name[cur_test], acc);
                        errors++;
                    end
                    acc_count++;
                end
                if (busy) begin
                    if (wait_cnt == 0) begin
                        if (write_request) begin
                            reg_mem[rw_address[7:0]] = write_data;
                        end else begin
                            read_data = reg_mem[rw_address[7:0]];
                        end
                        output_valid = 1'b1;
                    end else begin
                        wait_cnt--;
                    end
                end
            end

            // Master outputs come from registers, so this byte moves on the next edge
            m_tready = (rng[1:0] != 2'b00);
            if (m_tvalid && m_tready) begin
                got = {m_tlast, m_tdata};
                idx = out_count - out_base;
                if (idx < out_len[cur_test]) begin
                    check_value(test_name[cur_test],
                                $sformatf("output byte %0d {tlast, data}", idx),
                                out_bytes[cur_test][idx], got);
                end else begin
                    $display("Test %s: unexpected output byte %0h", test_name[cur_test], got);
                    errors++;
                end
                out_count++;
            end
        end
    end

    initial begin
        int err_start;
        int passed;
        int failed;
        passed   = 0;
        failed   = 0;
        rst_n    = 1'b0;
        s_tvalid = 1'b0;
        s_tdata  = 8'h00;
        s_tlast  = 1'b0;
        load_golden();
        cycle_limit = 200 * golden_bytes;
        repeat (16) @(posedge clk);
        @(negedge clk);

        // Stream and register outputs stay low while reset is held
        check_value("reset", "o_s_tready during reset", 64'd0, 64'(s_tready));
        check_value("reset", "o_m_tvalid during reset", 64'd0, 64'(m_tvalid));
        check_value("reset", "o_read_request during reset", 64'd0, 64'(read_request));
        check_value("reset", "o_write_request during reset", 64'd0, 64'(write_request));
        rst_n = 1'b1;
        @(negedge clk);
        // Slave side opens in the first cycle after reset
        check_value("reset", "o_s_tready after reset", 64'd1, 64'(s_tready));
        if (errors == 0) begin
            passed++;
            $display("test reset: pass");
        end else begin
            failed++;
            $display("test reset: fail, %0d errors", errors);
        end

        for (int t = 0; t < num_tests; t++) begin
            @(posedge clk);
            cur_test  = t;
            out_base  = out_count;
            acc_base  = acc_count;
            err_start = errors;
            @(negedge clk);
            for (int k = 0; k < in_len[t]; k++) begin
                send_byte(in_bytes[t][k]);
            end
            while ((out_count - out_base) < out_len[t] ||
                   (acc_count - acc_base) < acc_len[t]) begin
                @(posedge clk);
            end
            // Quiet period so that stray bytes or requests land in this test
            repeat (SETTLE_CYCLES) @(posedge clk);
            if (errors == err_start) begin
                passed++;
                $display("test %s: pass", test_name[t]);
            end else begin
                failed++;
                $display("test %s: fail, %0d errors", test_name[t], errors - err_start);
            end
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0 && !load_error && num_tests > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* axis_debug_decoder.sv */
`default_nettype none

module axis_debug_decoder #(
    parameter dbg_pkg::byte_t DEVICE_TYPE = 8'haa,
    parameter dbg_pkg::byte_t DEVICE_ID   = 8'h55,
    parameter int unsigned    ADDR_BYTES  = 2,
    parameter int unsigned    DATA_BYTES  = 3
) (
    input  wire                         i_clk,
    input  wire                         i_rst_n,

    // Slave stream, every packet is forwarded
    input  wire                         i_s_tvalid,
    output logic                        o_s_tready,
    input  wire  [7:0]                  i_s_tdata,
    input  wire                         i_s_tlast,

    // Master stream, forwarded packets and responses
    output logic                        o_m_tvalid,
    input  wire                         i_m_tready,
    output logic [7:0]                  o_m_tdata,
    output logic                        o_m_tlast,

    // Register port, request held until i_output_valid
    output logic [ADDR_BYTES*8-1:0]     o_rw_address,
    output logic [DATA_BYTES*8-1:0]     o_write_data,
    input  wire  [DATA_BYTES*8-1:0]     i_read_data,
    output logic                        o_read_request,
    output logic                        o_write_request,
    input  wire                         i_output_valid
);

    dbg_tap_if   tap_if ();
    dbg_byte_if  resp_if ();

    logic                     resp_valid;
    logic                     resp_ready;
    dbg_pkg::resp_kind_t      resp_kind;
    logic [ADDR_BYTES*8-1:0]  resp_address;
    logic [DATA_BYTES*8-1:0]  resp_data;

    dbg_stream_forwarder u_forwarder (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_s_tvalid (i_s_tvalid),
        .o_s_tready (o_s_tready),
        .i_s_tdata  (i_s_tdata),
        .i_s_tlast  (i_s_tlast),
        .o_m_tvalid (o_m_tvalid),
        .i_m_tready (i_m_tready),
        .o_m_tdata  (o_m_tdata),
        .o_m_tlast  (o_m_tlast),
        .tap        (tap_if),
        .resp       (resp_if)
    );

    dbg_cmd_parser #(
        .DEVICE_TYPE (DEVICE_TYPE),
        .DEVICE_ID   (DEVICE_ID),
        .ADDR_BYTES  (ADDR_BYTES),
        .DATA_BYTES  (DATA_BYTES)
    ) u_parser (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .tap             (tap_if),
        .o_rw_address    (o_rw_address),
        .o_write_data    (o_write_data),
        .i_read_data     (i_read_data),
        .o_read_request  (o_read_request),
        .o_write_request (o_write_request),
        .i_output_valid  (i_output_valid),
        .o_resp_valid    (resp_valid),
        .i_resp_ready    (resp_ready),
        .o_resp_kind     (resp_kind),
        .o_resp_address  (resp_address),
        .o_resp_data     (resp_data)
    );

    dbg_resp_builder #(
        .DEVICE_TYPE (DEVICE_TYPE),
        .DEVICE_ID   (DEVICE_ID),
        .ADDR_BYTES  (ADDR_BYTES),
        .DATA_BYTES  (DATA_BYTES)
    ) u_builder (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_resp_valid   (resp_valid),
        .o_resp_ready   (resp_ready),
        .i_resp_kind    (resp_kind),
        .i_resp_address (resp_address),
        .i_resp_data    (resp_data),
        .out            (resp_if)
    );

endmodule

`default_nettype wire

/* dbg_resp_builder.sv */
`default_nettype none

module dbg_resp_builder #(
    parameter dbg_pkg::byte_t DEVICE_TYPE = 8'haa,
    parameter dbg_pkg::byte_t DEVICE_ID   = 8'h55,
    parameter int unsigned    ADDR_BYTES  = 2,
    parameter int unsigned    DATA_BYTES  = 3
) (
    input  wire                         i_clk,
    input  wire                         i_rst_n,

    input  wire                         i_resp_valid,
    output logic                        o_resp_ready,
    input  dbg_pkg::resp_kind_t         i_resp_kind,
    input  wire  [ADDR_BYTES*8-1:0]     i_resp_address,
    input  wire  [DATA_BYTES*8-1:0]     i_resp_data,

    dbg_byte_if.src                     out
);

    typedef enum logic [3:0] {
        B_IDLE,
        B_VERSION,
        B_TYPE,
        B_DEV_TYPE,
        B_DEV_ID,
        B_ADDR_W,
        B_DATA_W,
        B_ADDR,
        B_DATA
    } build_state_t;

    build_state_t             state;
    dbg_pkg::field_cnt_t      cnt;
    dbg_pkg::resp_kind_t      kind_q;
    logic [ADDR_BYTES*8-1:0]  addr_q;
    logic [DATA_BYTES*8-1:0]  data_q;
    logic                     accept;
    logic                     fire;

    assign o_resp_ready = (state == B_IDLE);
    assign accept       = i_resp_valid && o_resp_ready;
    assign fire         = out.valid && out.ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= B_IDLE;
            cnt   <= '0;
        end else if (accept) begin
            state <= B_VERSION;
        end else if (fire) begin
            cnt <= cnt - 1'b1;
            case (state)
                B_VERSION:  state <= B_TYPE;
                B_TYPE:     state <= B_DEV_TYPE;
                B_DEV_TYPE: state <= B_DEV_ID;
                B_DEV_ID: begin
                    state <= (kind_q == dbg_pkg::IDENTIFY) ? B_ADDR_W : B_ADDR;
                    cnt   <= dbg_pkg::field_cnt_t'(ADDR_BYTES - 1);
                end
                B_ADDR_W:   state <= B_DATA_W;
                B_ADDR: begin
                    if (cnt == '0) begin
                        state <= B_DATA;
                        cnt   <= dbg_pkg::field_cnt_t'(DATA_BYTES - 1);
                    end
                end
                B_DATA: begin
                    if (cnt == '0) begin
                        state <= B_IDLE;
                    end
                end
                default:    state <= B_IDLE;
            endcase
        end
    end

    // Request fields are held here, address and data shift out MSB first
    always_ff @(posedge i_clk) begin
        if (accept) begin
            kind_q <= i_resp_kind;
            addr_q <= i_resp_address;
            data_q <= i_resp_data;
        end else if (fire && state == B_ADDR) begin
            addr_q <= addr_q << 8;
        end else if (fire && state == B_DATA) begin
            data_q <= data_q << 8;
        end
    end

    always_comb begin
        case (state)
            B_VERSION:  out.data = dbg_pkg::PROTOCOL_VERSION;
            B_TYPE:     out.data = (kind_q == dbg_pkg::IDENTIFY) ? dbg_pkg::RESP_IDENTIFY
                                                                 : dbg_pkg::RESP_READ;
            B_DEV_TYPE: out.data = DEVICE_TYPE;
            B_DEV_ID:   out.data = DEVICE_ID;
            B_ADDR_W:   out.data = dbg_pkg::byte_t'(ADDR_BYTES);
            B_DATA_W:   out.data = dbg_pkg::byte_t'(DATA_BYTES);
            B_ADDR:     out.data = addr_q[ADDR_BYTES*8-1 -: 8];
            B_DATA:     out.data = data_q[DATA_BYTES*8-1 -: 8];
            default:    out.data = '0;
        endcase
    end

    assign out.valid = (state != B_IDLE);
    assign out.last  = (state == B_DATA_W) || (state == B_DATA && cnt == '0);

endmodule

`default_nettype wire

/* dbg_cmd_parser.sv */
`default_nettype none

module dbg_cmd_parser #(
    parameter dbg_pkg::byte_t DEVICE_TYPE = 8'haa,
    parameter dbg_pkg::byte_t DEVICE_ID   = 8'h55,
    parameter int unsigned    ADDR_BYTES  = 2,
    parameter int unsigned    DATA_BYTES  = 3
) (
    input  wire                         i_clk,
    input  wire                         i_rst_n,

    dbg_tap_if.snk                      tap,

    output logic [ADDR_BYTES*8-1:0]     o_rw_address,
    output logic [DATA_BYTES*8-1:0]     o_write_data,
    input  wire  [DATA_BYTES*8-1:0]     i_read_data,
    output logic                        o_read_request,
    output logic                        o_write_request,
    input  wire                         i_output_valid,

    output logic                        o_resp_valid,
    input  wire                         i_resp_ready,
    output dbg_pkg::resp_kind_t         o_resp_kind,
    output logic [ADDR_BYTES*8-1:0]     o_resp_address,
    output logic [DATA_BYTES*8-1:0]     o_resp_data
);

    typedef logic [ADDR_BYTES*8-1:0] addr_t;
    typedef logic [DATA_BYTES*8-1:0] data_t;

    typedef enum logic [2:0] {
        P_IDLE,
        P_CMD,
        P_DEV_TYPE,
        P_DEV_ID,
        P_ADDR,
        P_DATA,
        P_REG_WAIT,
        P_RESP_WAIT
    } parse_state_t;

    parse_state_t         state;
    dbg_pkg::field_cnt_t  cnt;
    logic                 is_write;
    addr_t                addr_q;
    data_t                wdata_q;
    data_t                rdata_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state           <= P_IDLE;
            cnt             <= '0;
            is_write        <= 1'b0;
            o_read_request  <= 1'b0;
            o_write_request <= 1'b0;
            o_resp_valid    <= 1'b0;
        end else begin
            case (state)
                P_IDLE: begin
                    if (tap.valid && tap.first && !tap.last &&
                        tap.data == dbg_pkg::PROTOCOL_VERSION) begin
                        state <= P_CMD;
                    end
                end
                P_CMD: begin
                    if (tap.valid) begin
                        if (tap.data == dbg_pkg::CMD_IDENTIFY) begin
                            o_resp_valid <= 1'b1;
                            state        <= P_RESP_WAIT;
                        end else if (!tap.last && (tap.data == dbg_pkg::CMD_READ ||
                                                   tap.data == dbg_pkg::CMD_WRITE)) begin
                            is_write <= (tap.data == dbg_pkg::CMD_WRITE);
                            state    <= P_DEV_TYPE;
                        end else begin
                            state <= P_IDLE;
                        end
                    end
                end
                P_DEV_TYPE: begin
                    if (tap.valid) begin
                        state <= (tap.data == DEVICE_TYPE && !tap.last) ? P_DEV_ID : P_IDLE;
                    end
                end
                P_DEV_ID: begin
                    if (tap.valid) begin
                        state <= (tap.data == DEVICE_ID && !tap.last) ? P_ADDR : P_IDLE;
                        cnt   <= dbg_pkg::field_cnt_t'(ADDR_BYTES - 1);
                    end
                end
                P_ADDR: begin
                    if (tap.valid) begin
                        cnt <= cnt - 1'b1;
                        if (cnt == '0) begin
                            if (!is_write) begin
                                o_read_request <= 1'b1;
                                state          <= P_REG_WAIT;
                            end else if (tap.last) begin
                                state <= P_IDLE;
                            end else begin
                                cnt   <= dbg_pkg::field_cnt_t'(DATA_BYTES - 1);
                                state <= P_DATA;
                            end
                        end else if (tap.last) begin
                            state <= P_IDLE;
                        end
                    end
                end
                P_DATA: begin
                    if (tap.valid) begin
                        cnt <= cnt - 1'b1;
                        if (cnt == '0) begin
                            o_write_request <= 1'b1;
                            state           <= P_REG_WAIT;
                        end else if (tap.last) begin
                            state <= P_IDLE;
                        end
                    end
                end
                P_REG_WAIT: begin
                    if (i_output_valid) begin
                        o_read_request  <= 1'b0;
                        o_write_request <= 1'b0;
                        o_resp_valid    <= !is_write;
                        state           <= is_write ? P_IDLE : P_RESP_WAIT;
                    end
                end
                P_RESP_WAIT: begin
                    if (i_resp_ready) begin
                        o_resp_valid <= 1'b0;
                        state        <= P_IDLE;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // Fields arrive MSB first and are shifted in from the bottom
    always_ff @(posedge i_clk) begin
        if (state == P_CMD && tap.valid) begin
            o_resp_kind <= (tap.data == dbg_pkg::CMD_IDENTIFY) ? dbg_pkg::IDENTIFY
                                                               : dbg_pkg::READ;
        end
        if (state == P_ADDR && tap.valid) begin
            addr_q <= addr_t'({addr_q, tap.data});
        end
        if (state == P_DATA && tap.valid) begin
            wdata_q <= data_t'({wdata_q, tap.data});
        end
        if (state == P_REG_WAIT && i_output_valid && !is_write) begin
            rdata_q <= i_read_data;
        end
    end

    assign o_rw_address   = addr_q;
    assign o_write_data   = wdata_q;
    assign o_resp_address = addr_q;
    assign o_resp_data    = rdata_q;

endmodule

`default_nettype wire

/* dbg_stream_forwarder.sv */
`default_nettype none

module dbg_stream_forwarder (
    input  wire             i_clk,
    input  wire             i_rst_n,

    input  wire             i_s_tvalid,
    output logic            o_s_tready,
    input  wire  [7:0]      i_s_tdata,
    input  wire             i_s_tlast,

    output logic            o_m_tvalid,
    input  wire             i_m_tready,
    output dbg_pkg::byte_t  o_m_tdata,
    output logic            o_m_tlast,

    dbg_tap_if.src          tap,
    dbg_byte_if.snk         resp
);

    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        INSERT
    } fwd_state_t;

    fwd_state_t      state;
    fwd_state_t      state_nxt;

    // Two-entry buffer between slave and master
    dbg_pkg::byte_t  buf_data [2];
    logic            buf_last [2];
    logic            wr_ptr;
    logic            rd_ptr;
    logic [1:0]      count;
    logic [1:0]      count_nxt;

    logic            in_packet;
    logic            in_packet_nxt;
    logic            s_ready_q;
    logic            s_ready_nxt;
    logic            push;
    logic            pop;

    assign o_s_tready = s_ready_q;
    assign push       = i_s_tvalid && s_ready_q;
    assign pop        = (state != INSERT) && (count != 2'd0) && i_m_tready;

    always_comb begin
        count_nxt     = count + {1'b0, push} - {1'b0, pop};
        in_packet_nxt = push ? !i_s_tlast : in_packet;

        state_nxt = state;
        case (state)
            IDLE: begin
                // A byte accepted in this cycle wins over a waiting response
                if (push) begin
                    state_nxt = FORWARD;
                end else if (resp.valid) begin
                    state_nxt = INSERT;
                end
            end
            FORWARD: begin
                if (!in_packet_nxt && count_nxt == 2'd0) begin
                    state_nxt = resp.valid ? INSERT : IDLE;
                end
            end
            INSERT: begin
                if (resp.valid && resp.last && i_m_tready) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase

        // Closed once tlast is held until that byte has gone out
        s_ready_nxt = (state_nxt != INSERT) &&
                      (in_packet_nxt ? (count_nxt != 2'd2) : (count_nxt == 2'd0));
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= IDLE;
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
            count     <= 2'd0;
            in_packet <= 1'b0;
            s_ready_q <= 1'b0;
        end else begin
            state     <= state_nxt;
            count     <= count_nxt;
            in_packet <= in_packet_nxt;
            s_ready_q <= s_ready_nxt;
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            buf_data[wr_ptr] <= i_s_tdata;
            buf_last[wr_ptr] <= i_s_tlast;
        end
    end

    // Master side is fed by the response while inserting
    assign o_m_tvalid = (state == INSERT) ? resp.valid : (count != 2'd0);
    assign o_m_tdata  = (state == INSERT) ? resp.data  : buf_data[rd_ptr];
    assign o_m_tlast  = (state == INSERT) ? resp.last  : buf_last[rd_ptr];
    assign resp.ready = (state == INSERT) && i_m_tready;

    assign tap.valid = push;
    assign tap.data  = i_s_tdata;
    assign tap.first = !in_packet;
    assign tap.last  = i_s_tlast;

endmodule

`default_nettype wire

/* dbg_ifs.sv */
`default_nettype none

// Copy of every byte accepted on the slave stream, with packet boundaries
interface dbg_tap_if;
    logic            valid;
    dbg_pkg::byte_t  data;
    logic            first;
    logic            last;

    modport src (
        output valid, data, first, last
    );

    modport snk (
        input valid, data, first, last
    );
endinterface

// Response bytes, valid/ready handshake
interface dbg_byte_if;
    logic            valid;
    logic            ready;
    dbg_pkg::byte_t  data;
    logic            last;

    modport src (
        output valid, data, last,
        input  ready
    );

    modport snk (
        input  valid, data, last,
        output ready
    );
endinterface

`default_nettype wire

/* dbg_pkg.sv */
`default_nettype none

package dbg_pkg;

    // One byte on the debug stream
    typedef logic [7:0] byte_t;

    // First byte of every decodable packet and of every response
    localparam byte_t PROTOCOL_VERSION = 8'h01;

    // Command codes, second byte of a request
    localparam byte_t CMD_IDENTIFY = 8'h00;
    localparam byte_t CMD_READ     = 8'h02;
    localparam byte_t CMD_WRITE    = 8'h04;

    // Response type codes, second byte of a response
    localparam byte_t RESP_IDENTIFY = 8'h01;
    localparam byte_t RESP_READ     = 8'h03;

    // Which response the builder has to serialize
    typedef enum logic {
        IDENTIFY,
        READ
    } resp_kind_t;

    // Widest address or data field in bytes
    localparam int unsigned MAX_FIELD_BYTES = 8;

    // Counts the bytes of one address or data field
    typedef logic [$clog2(MAX_FIELD_BYTES + 1)-1:0] field_cnt_t;

endpackage

`default_nettype wire
